//--- Makefile
SOURCES := $(shell cat list.f)

.PHONY: run clean

run: obj_dir/VcpuCoreTb
	./obj_dir/VcpuCoreTb | tee sim.log
	@grep -q "^Test OK$$" sim.log

obj_dir/VcpuCoreTb: list.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module cpuCoreTb -f list.f

clean:
	rm -rf obj_dir sim.log

//--- list.f
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/dataMemory.sv
verilog/fetchUnit.sv
verilog/cpuCore.sv
tb/cpuCoreTb.sv

//--- tb/cpuCoreTb.sv
module cpuCoreTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int progWords = 512;
	localparam int numInstrs = 2000;
	localparam int clkPeriod = 40;
	localparam int timeoutNs = numInstrs * 4 * clkPeriod;

	logic clk;
	logic reset;
	logic instrValid;
	logic [cpuPkg::instrWidth-1:0] instr;
	logic instrReady;
	logic [cpuPkg::pcWidth-1:0] pc;
	logic retireValid;
	logic [cpuPkg::pcWidth-1:0] retirePc;
	logic retireWe;
	logic [cpuPkg::regAddrWidth-1:0] retireReg;
	logic [cpuPkg::dataWidth-1:0] retireData;

	logic [31:0] progMem [progWords];
	logic [15:0] mRegs [cpuPkg::numRegs];
	logic [7:0] mMem [cpuPkg::memBytes];
	logic [15:0] mPc;
	logic [37:0] expQ [$]; // {pc, we, reg, data}
	int errCount [3]; // pc/handshake, retire, reset
	int accepted;

	cpuCore cpuCore_inst (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrReady(instrReady),
		.pc(pc),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireWe(retireWe),
		.retireReg(retireReg),
		.retireData(retireData)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkField(input string name, input int kind, input logic [15:0] expVal,
			input logic [15:0] actVal);
		assert (actVal === expVal) else begin
			errCount[kind]++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic genProgram();
		cpuPkg::opcode_t op;
		cpuPkg::funct_t fn;
		logic [4:0] rs, rt, rd;
		logic [15:0] imm;
		int kind;
		int sel;
		int target;
		for (int i = 0; i < progWords; i++) begin
			rs = 5'($urandom_range(7)); // few registers for more data reuse
			rt = 5'($urandom_range(7));
			rd = 5'($urandom_range(7));
			imm = 16'($urandom);
			kind = int'($urandom_range(99));
			sel = int'($urandom_range(5));
			if (kind < 5) begin
				do fn = 6'($urandom);
				while (fn inside {cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
					cpuPkg::fnOr, cpuPkg::fnNor, cpuPkg::fnSlt});
				progMem[i] = {cpuPkg::opRType, rs, rt, rd, 5'b0, fn};
			end else if (kind < 10) begin
				do op = 6'($urandom);
				while (op inside {cpuPkg::opRType, cpuPkg::opAddi, cpuPkg::opAndi,
					cpuPkg::opOri, cpuPkg::opSlti, cpuPkg::opBeq, cpuPkg::opJ,
					cpuPkg::opLh, cpuPkg::opSh});
				progMem[i] = {op, rs, rt, imm};
			end else if (kind < 40) begin
				case (sel)
					0: fn = cpuPkg::fnAdd;
					1: fn = cpuPkg::fnSub;
					2: fn = cpuPkg::fnAnd;
					3: fn = cpuPkg::fnOr;
					4: fn = cpuPkg::fnNor;
					default: fn = cpuPkg::fnSlt;
				endcase
				progMem[i] = {cpuPkg::opRType, rs, rt, rd, 5'b0, fn};
			end else if (kind < 60) begin
				case (sel % 4)
					0: op = cpuPkg::opAddi;
					1: op = cpuPkg::opAndi;
					2: op = cpuPkg::opOri;
					default: op = cpuPkg::opSlti;
				endcase
				progMem[i] = {op, rs, rt, imm};
			end else if (kind < 70) begin
				// backward targets at least 8 words behind the branch
				if (i >= 8 && $urandom_range(3) == 0) begin
					target = int'($urandom_range(i - 8));
				end else begin
					target = int'($urandom_range(progWords - 1, i + 1));
				end
				progMem[i] = {cpuPkg::opBeq, rs, rt, 16'(target - i - 1)};
			end else if (kind < 75) begin
				target = int'($urandom_range(progWords - 1, i + 1)); // forward only
				progMem[i] = {cpuPkg::opJ, 26'(target)};
			end else begin
				if ($urandom_range(1) == 0) begin
					rs = 5'd0;
					imm = 16'(248 + $urandom_range(11)); // near 255 so the low byte wraps to 0
				end
				op = ($urandom_range(1) == 0) ? cpuPkg::opLh : cpuPkg::opSh;
				progMem[i] = {op, rs, rt, imm};
			end
		end
		progMem[progWords-1] = {cpuPkg::opJ, 26'd0}; // back to start
	endtask

	task automatic modelStep(input logic [31:0] w);
		cpuPkg::opcode_t op;
		cpuPkg::funct_t fn;
		logic [4:0] rs, rt, dest;
		logic [15:0] imm, a, b, res, nextPc;
		logic [7:0] addr;
		logic wr;
		logic we;
		op = w[31:26];
		fn = w[5:0];
		rs = w[25:21];
		rt = w[20:16];
		imm = w[15:0];
		a = mRegs[rs];
		b = mRegs[rt];
		dest = rt;
		res = '0;
		wr = 1'b0;
		addr = a[7:0] + imm[7:0];
		nextPc = mPc + 16'd4;
		case (op)
			cpuPkg::opRType: begin
				dest = w[15:11];
				wr = 1'b1;
				case (fn)
					cpuPkg::fnAdd: res = a + b;
					cpuPkg::fnSub: res = a - b;
					cpuPkg::fnAnd: res = a & b;
					cpuPkg::fnOr: res = a | b;
					cpuPkg::fnNor: res = ~(a | b);
					cpuPkg::fnSlt: res = {15'd0, $signed(a) < $signed(b)};
					default: wr = 1'b0;
				endcase
			end
			cpuPkg::opAddi: begin
				res = a + imm;
				wr = 1'b1;
			end
			cpuPkg::opAndi: begin
				res = a & imm;
				wr = 1'b1;
			end
			cpuPkg::opOri: begin
				res = a | imm;
				wr = 1'b1;
			end
			cpuPkg::opSlti: begin
				res = {15'd0, $signed(a) < $signed(imm)};
				wr = 1'b1;
			end
			cpuPkg::opBeq: begin
				if (a == b) nextPc = mPc + 16'd4 + {imm[13:0], 2'b00};
			end
			cpuPkg::opJ: nextPc = {w[13:0], 2'b00};
			cpuPkg::opLh: begin
				res = {mMem[addr], mMem[addr + 8'd1]}; // big-endian
				wr = 1'b1;
			end
			cpuPkg::opSh: begin
				mMem[addr] = b[15:8];
				mMem[addr + 8'd1] = b[7:0];
			end
			default: ;
		endcase
		we = wr && (dest != 5'd0);
		if (we) mRegs[dest] = res;
		expQ.push_back({mPc, we, dest, we ? res : 16'd0});
		mPc = nextPc;
	endtask

	task automatic checkRetire();
		logic [37:0] e;
		if (expQ.size() != 0) begin
			e = expQ.pop_front();
			checkField("retireValid", 1, 16'd1, 16'(retireValid));
			checkField("retirePc", 1, e[37:22], retirePc);
			checkField("retireWe", 1, 16'(e[21]), 16'(retireWe));
			if (e[21]) checkField("retireReg", 1, 16'(e[20:16]), 16'(retireReg));
			checkField("retireData", 1, e[15:0], retireData);
		end else begin
			checkField("retireValid", 1, 16'd0, 16'(retireValid)); // idle cycle
			checkField("retireWe", 1, 16'd0, 16'(retireWe));
		end
	endtask

	task automatic driveNext();
		if (accepted < numInstrs) begin
			instrValid = ($urandom_range(3) != 0); // about 75% valid
		end else begin
			instrValid = 1'b0;
		end
		instr = progMem[pc[10:2]];
		if (instrValid && instrReady) begin
			modelStep(instr);
			accepted++;
		end
	endtask

	initial begin
		void'($urandom(32'h238c_bbb8));
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		accepted = 0;
		mPc = '0;
		for (int i = 0; i < cpuPkg::numRegs; i++) mRegs[i] = '0;
		for (int i = 0; i < cpuPkg::memBytes; i++) mMem[i] = '0;
		genProgram();
		repeat (4) begin
			@(negedge clk);
			checkField("instrReady", 2, 16'd0, 16'(instrReady));
			checkField("retireValid", 2, 16'd0, 16'(retireValid));
			checkField("retireWe", 2, 16'd0, 16'(retireWe));
		end
		reset = 1'b0;
		instrValid = 1'b1; // offered while instrReady is still low
		instr = progMem[0];
		while (accepted < numInstrs || expQ.size() != 0) begin
			@(negedge clk);
			checkRetire();
			checkField("pc", 0, mPc, pc);
			checkField("instrReady", 0, 16'd1, 16'(instrReady));
			driveNext();
		end
		$display("Summary: pc/handshake errors %0d, retire errors %0d, reset errors %0d",
			errCount[0], errCount[1], errCount[2]);
		if (errCount[0] + errCount[1] + errCount[2] == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#timeoutNs;
		$display("Timeout after %0d ns, only %0d of %0d instructions accepted",
			timeoutNs, accepted, numInstrs);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- verilog/alu.sv
module alu (
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	input cpuPkg::aluOp_t op,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr: result = a | b;
			cpuPkg::aluAdd: result = a + b;
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluNor: result = ~(a | b);
			cpuPkg::aluSlt: begin
				result = '0;
				result[0] = $signed(a) < $signed(b); // signed compare
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- verilog/cpuCore.sv
module cpuCore (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [cpuPkg::instrWidth-1:0] instr,
	output logic instrReady,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic retireValid,
	output logic [cpuPkg::pcWidth-1:0] retirePc,
	output logic retireWe,
	output logic [cpuPkg::regAddrWidth-1:0] retireReg,
	output logic [cpuPkg::dataWidth-1:0] retireData
);

	logic accept;
	cpuPkg::aluOp_t aluOp;
	logic useImm, writeRd, regWrite, memRead, memWrite, branch, jump;
	logic [cpuPkg::regAddrWidth-1:0] rs, rt, rd, destReg;
	logic [cpuPkg::dataWidth-1:0] imm;
	logic [cpuPkg::dataWidth-1:0] rsData, rtData, aluB, aluResult, memData, writeBack;
	logic zero, rfWe, memWe, retireWrite;

	assign rs = instr[cpuPkg::rsHi:cpuPkg::rsLo];
	assign rt = instr[cpuPkg::rtHi:cpuPkg::rtLo];
	assign rd = instr[cpuPkg::rdHi:cpuPkg::rdLo];
	assign imm = instr[cpuPkg::immHi:cpuPkg::immLo];

	assign destReg = writeRd ? rd : rt;
	assign aluB = useImm ? imm : rtData;
	assign writeBack = memRead ? memData : aluResult;
	assign rfWe = regWrite & accept;
	assign memWe = memWrite & accept;
	assign retireWrite = rfWe && destReg != '0; // r0 writes are dropped

	fetchUnit fetch (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.pc(pc),
		.accept(accept),
		.branchTaken(branch & zero),
		.jump(jump),
		.branchOffset(imm),
		.jumpIndex(instr[cpuPkg::jumpHi:cpuPkg::jumpLo])
	);

	instrDecoder decoder (
		.opcode(instr[cpuPkg::opcodeHi:cpuPkg::opcodeLo]),
		.funct(instr[cpuPkg::functHi:cpuPkg::functLo]),
		.aluOp(aluOp),
		.useImm(useImm),
		.writeRd(writeRd),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.branch(branch),
		.jump(jump)
	);

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.rs(rs),
		.rt(rt),
		.rd(destReg),
		.writeEnable(rfWe),
		.writeData(writeBack),
		.rsData(rsData),
		.rtData(rtData)
	);

	alu alu0 (
		.a(rsData),
		.b(aluB),
		.op(aluOp),
		.result(aluResult),
		.zero(zero)
	);

	dataMemory dmem (
		.clk(clk),
		.reset(reset),
		.addr(aluResult[cpuPkg::memAddrWidth-1:0]),
		.writeEnable(memWe),
		.writeData(rtData),
		.readData(memData)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			retireValid <= 1'b0;
			retireWe <= 1'b0;
		end else begin
			retireValid <= accept;
			retireWe <= retireWrite;
		end
	end

	// retire payload, only meaningful with retireValid
	always_ff @(posedge clk) begin
		if (accept) begin
			retirePc <= pc;
			retireReg <= destReg;
			retireData <= retireWrite ? writeBack : '0;
		end
	end

endmodule

//--- verilog/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int instrWidth = 32;
	localparam int pcWidth = 16;
	localparam int regAddrWidth = 5;
	localparam int numRegs = 32;
	localparam int memAddrWidth = 8;
	localparam int memBytes = 256;

	typedef enum logic [2:0] {
		aluAnd,
		aluOr,
		aluAdd,
		aluSub,
		aluNor,
		aluSlt
	} aluOp_t;

	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	localparam opcode_t opRType = 6'b000000;
	localparam opcode_t opAddi = 6'b001000;
	localparam opcode_t opAndi = 6'b001100;
	localparam opcode_t opOri = 6'b001101;
	localparam opcode_t opSlti = 6'b001010;
	localparam opcode_t opBeq = 6'b000100;
	localparam opcode_t opJ = 6'b000010;
	localparam opcode_t opLh = 6'b100001;
	localparam opcode_t opSh = 6'b101001;

	localparam funct_t fnAdd = 6'b100000;
	localparam funct_t fnSub = 6'b100010;
	localparam funct_t fnAnd = 6'b100100;
	localparam funct_t fnOr = 6'b100101;
	localparam funct_t fnNor = 6'b100111;
	localparam funct_t fnSlt = 6'b101010;

	// instruction field positions
	localparam int opcodeHi = 31;
	localparam int opcodeLo = 26;
	localparam int rsHi = 25;
	localparam int rsLo = 21;
	localparam int rtHi = 20;
	localparam int rtLo = 16;
	localparam int rdHi = 15;
	localparam int rdLo = 11;
	localparam int functHi = 5;
	localparam int functLo = 0;
	localparam int immHi = 15;
	localparam int immLo = 0;
	localparam int jumpHi = 25;
	localparam int jumpLo = 0;

endpackage

//--- verilog/dataMemory.sv
module dataMemory (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::memAddrWidth-1:0] addr,
	input logic writeEnable,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readData
);

	logic [7:0] mem [cpuPkg::memBytes];
	logic [cpuPkg::memAddrWidth-1:0] addrNext;

	assign addrNext = addr + cpuPkg::memAddrWidth'(1); // wraps 255 -> 0

	// big-endian, high byte at addr
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::memBytes; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEnable) begin
			mem[addr] <= writeData[15:8];
			mem[addrNext] <= writeData[7:0];
		end
	end

	assign readData = {mem[addr], mem[addrNext]};

endmodule

//--- verilog/fetchUnit.sv
module fetchUnit (
	input logic clk,
	input logic reset,
	input logic instrValid,
	output logic instrReady,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic accept,
	input logic branchTaken,
	input logic jump,
	input logic [cpuPkg::dataWidth-1:0] branchOffset,
	input logic [cpuPkg::jumpHi-cpuPkg::jumpLo:0] jumpIndex
);

	logic [cpuPkg::pcWidth-1:0] pcPlus4;
	logic [cpuPkg::pcWidth-1:0] offsetBytes;
	logic [cpuPkg::pcWidth-1:0] jumpTarget;
	logic [cpuPkg::pcWidth-1:0] nextPc;

	assign accept = instrValid & instrReady;

	assign pcPlus4 = pc + cpuPkg::pcWidth'(4);
	assign offsetBytes = cpuPkg::pcWidth'($signed(branchOffset)) << 2; // word offset
	assign jumpTarget = cpuPkg::pcWidth'({jumpIndex, 2'b00});

	always_comb begin
		if (jump) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = pcPlus4 + offsetBytes;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			instrReady <= 1'b0;
			pc <= '0;
		end else begin
			instrReady <= 1'b1; // never stalls once out of reset
			if (accept) begin
				pc <= nextPc;
			end
		end
	end

endmodule

//--- verilog/instrDecoder.sv
module instrDecoder (
	input cpuPkg::opcode_t opcode,
	input cpuPkg::funct_t funct,
	output cpuPkg::aluOp_t aluOp,
	output logic useImm,
	output logic writeRd,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic branch,
	output logic jump
);

	always_comb begin
		aluOp = cpuPkg::aluAdd;
		useImm = 1'b0;
		writeRd = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		case (opcode)
			cpuPkg::opRType: begin
				writeRd = 1'b1;
				regWrite = 1'b1;
				case (funct)
					cpuPkg::fnAdd: aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
					cpuPkg::fnNor: aluOp = cpuPkg::aluNor;
					cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
					default: begin
						writeRd = 1'b0; // unknown funct, no-op
						regWrite = 1'b0;
					end
				endcase
			end
			cpuPkg::opAddi: begin
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opAndi: begin
				aluOp = cpuPkg::aluAnd;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opOri: begin
				aluOp = cpuPkg::aluOr;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opSlti: begin
				aluOp = cpuPkg::aluSlt;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opBeq: begin
				aluOp = cpuPkg::aluSub; // zero flag gives equality
				branch = 1'b1;
			end
			cpuPkg::opJ: begin
				jump = 1'b1;
			end
			cpuPkg::opLh: begin
				useImm = 1'b1; // address is rs + imm
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			cpuPkg::opSh: begin
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/registerFile.sv
module registerFile (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::regAddrWidth-1:0] rs,
	input logic [cpuPkg::regAddrWidth-1:0] rt,
	input logic [cpuPkg::regAddrWidth-1:0] rd,
	input logic writeEnable,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] rsData,
	output logic [cpuPkg::dataWidth-1:0] rtData
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && rd != '0) begin // r0 stays zero
			regs[rd] <= writeData;
		end
	end

	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule
